// File: issue_stage.f
+incdir+logic
logic/apogeo_pkg.sv
logic/register_file.sv
logic/scoreboard.sv
logic/scheduler.sv
logic/integer_unit.sv
logic/issue_stage.sv
dv/tb_clock.sv
dv/issue_stage_chk.sv
dv/issue_stage_tb.sv

// File: run.sh
#!/bin/sh
# Compile the issue stage testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f issue_stage.f --top-module issue_stage_tb \
    -o sim_issue_stage

./obj_dir/sim_issue_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "Simulation ended without a pass line."
    exit 1
fi

// File: dv/issue_stage_tb.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module issue_stage_tb
    import apogeo_pkg::*;
;

    localparam int NUM_RANDOM  = 200;
    localparam int TEST_CYCLES = (31 + 2 * NUM_RANDOM + 60) * 6;
    localparam int WATCHDOG_NS = TEST_CYCLES * 40 + 2000;   // Cycle budget plus margin.

    typedef struct packed {
        data_word_t                 data;
        logic [4:0]                 rd;
        logic [`ISSUE_TAG_BITS-1:0] tag;
        logic                       taken;
        data_word_t                 target;
    } result_t;

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       flush_i;
    logic                       instr_valid_i;
    logic                       instr_ready_o;
    exu_uop_t                   uop_i;
    logic                       is_branch_i;
    logic                       jump_i;
    logic                       compressed_i;
    logic                       fence_i;
    logic                       target_base_i;
    logic [1:0][4:0]            src_reg_i;
    logic [4:0]                 dest_reg_i;
    data_word_t [1:0]           imm_i;
    logic [1:0]                 imm_valid_i;
    data_word_t                 instr_address_i;
    logic                       result_valid_o;
    logic                       result_ready_i;
    logic                       result_taken_o;
    data_word_t                 result_data_o;
    data_word_t                 result_target_o;
    logic [4:0]                 result_reg_o;
    logic [`ISSUE_TAG_BITS-1:0] result_tag_o;

    data_word_t shadow [32];                        // Reference register values.
    result_t expected [$];                          // Results in issue order.
    logic [`ISSUE_TAG_BITS-1:0] exp_tag;
    logic rand_ready;
    result_t head;
    logic hazard;
    data_word_t last_x5;                            // Last value the DUT wrote to x5.

    tb_clock #(.PERIOD_NS(40)) i_clock (.clk_o(clk_i));

    issue_stage i_dut (.*);

    bind issue_stage issue_stage_chk i_chk (.*);

    task automatic report_mismatch(input string name, input data_word_t got,
                                   input data_word_t exp);
        $display("Error: time %0t signal %s value %h expected %h", $time, name, got, exp);
        $display("STATUS: FAIL");
        $fatal(1, "mismatch");
    endtask

    task automatic report_failure(input string what);
        $display("Failure at time %0t: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    function automatic data_word_t reg_value(input logic [4:0] r);
        return (r == 5'd0) ? '0 : shadow[r];        // x0 reads zero.
    endfunction

    function automatic logic is_pending(input logic [4:0] r);
        logic hit;
        hit = 1'b0;
        foreach (expected[i]) begin
            if (r != 5'd0 && expected[i].rd == r) hit = 1'b1;
        end
        return hit;
    endfunction

    // Reference result of the instruction now on the inputs.
    function automatic result_t predict();
        result_t    r;
        data_word_t a;
        data_word_t b;
        a = imm_valid_i[0] ? imm_i[0] : reg_value(src_reg_i[0]);
        b = imm_valid_i[1] ? imm_i[1] : reg_value(src_reg_i[1]);
        r.data   = '0;
        r.taken  = 1'b0;
        r.rd     = dest_reg_i;
        r.tag    = exp_tag;
        r.target = (target_base_i ? reg_value(src_reg_i[0]) : instr_address_i) + imm_i[1];
        if (jump_i) begin
            r.data  = instr_address_i + (compressed_i ? 32'd2 : 32'd4);
            r.taken = 1'b1;
        end else if (is_branch_i) begin
            case (uop_i.branch.cond)
                BR_EQ:   r.taken = (a == b);
                BR_NE:   r.taken = (a != b);
                BR_LT:   r.taken = ($signed(a) < $signed(b));
                BR_GE:   r.taken = ($signed(a) >= $signed(b));
                default: r.taken = 1'b1;
            endcase
        end else begin
            case (uop_i.alu.op)
                ALU_ADD: r.data = a + b;
                ALU_SUB: r.data = a - b;
                ALU_AND: r.data = a & b;
                ALU_OR:  r.data = a | b;
                ALU_XOR: r.data = a ^ b;
                ALU_SLT: r.data = {31'd0, $signed(a) < $signed(b)};
                ALU_SLL: r.data = a << b[4:0];
                default: r.data = a >> b[4:0];
            endcase
        end
        if (is_branch_i && !uop_i.branch.link) r.rd = 5'd0;  // No link, no write.
        return r;
    endfunction

    always @(posedge clk_i) begin
        if (rst_n_i) begin
            // Sources and a written destination must be free at transfer.
            if (is_branch_i && !uop_i.branch.link) begin
                hazard = 1'b0;
            end else begin
                hazard = is_pending(dest_reg_i);
            end
            if ((!jump_i && !imm_valid_i[0]) || target_base_i) begin
                hazard = hazard | is_pending(src_reg_i[0]);
            end
            if (!jump_i && !imm_valid_i[1]) hazard = hazard | is_pending(src_reg_i[1]);
            if (instr_valid_i && instr_ready_o && !fence_i && !flush_i) begin
                assert (!hazard) else report_failure("instruction issued over a pending register");
            end
            if (result_valid_o && result_ready_i) begin
                assert (expected.size() > 0) else report_failure("result with nothing issued");
                head = expected.pop_front();
                assert (result_data_o == head.data)
                    else report_mismatch("result_data_o", result_data_o, head.data);
                assert (result_reg_o == head.rd)
                    else report_mismatch("result_reg_o", 32'(result_reg_o), 32'(head.rd));
                assert (result_tag_o == head.tag)
                    else report_mismatch("result_tag_o", 32'(result_tag_o), 32'(head.tag));
                assert (result_taken_o == head.taken)
                    else report_mismatch("result_taken_o", 32'(result_taken_o), 32'(head.taken));
                assert (result_target_o == head.target)
                    else report_mismatch("result_target_o", result_target_o, head.target);
                if (head.rd != 5'd0) shadow[head.rd] = head.data;
                if (result_reg_o == 5'd5) last_x5 = result_data_o;
            end
            if (flush_i) begin
                expected.delete();                  // Issued work is dropped.
                exp_tag = '0;
            end else if (instr_valid_i && instr_ready_o && !fence_i) begin
                expected.push_back(predict());
                exp_tag = exp_tag + 1'b1;
                assert (expected.size() <= 2) else report_failure("more than two in flight");
            end
        end
    end

    always @(negedge clk_i) begin
        if (rand_ready) result_ready_i = ($urandom % 4) != 0;   // Mostly ready.
    end

    task automatic send_instr(input logic br, input logic jmp, input logic cmp,
                              input logic fen, input logic base, input logic [7:0] uop,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [4:0] rd, input data_word_t i0,
                              input data_word_t i1, input logic [1:0] iv);
        @(negedge clk_i);
        instr_valid_i   = 1'b1;
        is_branch_i     = br;
        jump_i          = jmp;
        compressed_i    = cmp;
        fence_i         = fen;
        target_base_i   = base;
        uop_i           = uop;
        src_reg_i       = {rs2, rs1};
        dest_reg_i      = rd;
        imm_i           = {i1, i0};
        imm_valid_i     = iv;
        instr_address_i = {15'd0, 16'($urandom), 1'b0};  // Halfword aligned PC.
        do @(posedge clk_i); while (!instr_ready_o);
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    task automatic send_random();
        logic [2:0] kind;
        logic [4:0] rd;
        kind = 3'($urandom % 8);
        rd   = 5'($urandom % 8);                    // Few registers, many hazards.
        if (kind < 3'd5) begin
            send_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'($urandom), {4'd0, 4'($urandom % 8)},
                       5'($urandom % 8), 5'($urandom % 8), rd, $urandom, $urandom,
                       2'($urandom));
        end else if (kind < 3'd7) begin
            send_instr(1'b1, 1'b0, 1'b0, 1'b0, 1'($urandom),
                       {4'd0, 1'($urandom), 3'($urandom % 5)}, 5'($urandom % 8),
                       5'($urandom % 8), rd, $urandom, $urandom, 2'($urandom));
        end else begin
            send_instr(1'b1, 1'b1, 1'($urandom), 1'b0, 1'($urandom), {4'd0, 1'b1, 3'(BR_ALWAYS)},
                       5'($urandom % 8), 5'd0, rd, '0, $urandom % 4096, 2'b00);
        end
    endtask

    task automatic wait_drained();
        while (expected.size() != 0) @(negedge clk_i);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the run did not finish in time.");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        data_word_t start;
        data_word_t sum;
        void'($urandom(32'h5aa1_0fac));
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        instr_valid_i = 1'b0;
        uop_i = '0;
        {is_branch_i, jump_i, compressed_i, fence_i, target_base_i} = '0;
        src_reg_i = '0;
        dest_reg_i = '0;
        imm_i = '0;
        imm_valid_i = '0;
        instr_address_i = '0;
        result_ready_i = 1'b1;
        rand_ready = 1'b0;
        exp_tag = '0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // Load every register with a known value.
        for (int r = 1; r < 32; r++) begin
            send_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, {4'd0, 4'(ALU_ADD)}, 5'd0, 5'd0,
                       5'(r), $urandom, $urandom, 2'b11);
        end
        rand_ready = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) send_random();

        // Dependent ADD chain on x5.
        wait_drained();
        start = shadow[5];
        sum   = '0;
        for (int n = 0; n < 8; n++) begin
            send_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, {4'd0, 4'(ALU_ADD)}, 5'd5, 5'd0,
                       5'd5, '0, 32'(n * 7 + 3), 2'b10);
            sum = sum + 32'(n * 7 + 3);
        end
        wait_drained();
        assert (last_x5 == start + sum) else report_mismatch("x5", last_x5, start + sum);

        // Back-pressure fills the queue and stops issue.
        rand_ready = 1'b0;
        @(negedge clk_i);
        result_ready_i = 1'b0;
        send_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'(ALU_XOR), 5'd0, 5'd0, 5'd9, 1, 2, 2'b11);
        send_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'(ALU_OR), 5'd0, 5'd0, 5'd10, 4, 8, 2'b11);
        repeat (4) begin
            @(negedge clk_i);
            assert (!instr_ready_o) else report_failure("issue accepted with a full queue");
        end
        result_ready_i = 1'b1;
        send_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'(ALU_SUB), 5'd9, 5'd10, 5'd11, 0, 0, 2'b00);

        // Fence behind outstanding results.
        rand_ready = 1'b1;
        send_random();
        send_random();
        send_instr(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 8'd0, 5'd0, 5'd0, 5'd0, 0, 0, 2'b11);

        // Flush drops queued work and resets the tag.
        rand_ready = 1'b0;
        wait_drained();
        @(negedge clk_i);
        result_ready_i = 1'b0;
        send_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'(ALU_ADD), 5'd0, 5'd0, 5'd12, 5, 6, 2'b11);
        send_instr(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 8'(ALU_SUB), 5'd0, 5'd0, 5'd13, 9, 3, 2'b11);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        rand_ready = 1'b1;
        for (int n = 0; n < 20; n++) send_random();
        wait_drained();

        $display("STATUS: PASS");
        $finish;
    end

endmodule : issue_stage_tb

// File: dv/issue_stage_chk.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module issue_stage_chk
    import apogeo_pkg::*;
(
    input logic                       clk_i,
    input logic                       rst_n_i,
    input logic                       flush_i,
    input logic                       instr_valid_i,
    input logic                       instr_ready_o,
    input logic                       fence_i,
    input logic                       is_branch_i,
    input exu_uop_t                   uop_i,
    input logic [4:0]                 dest_reg_i,
    input logic                       result_valid_o,
    input logic                       result_ready_i,
    input data_word_t                 result_data_o,
    input logic [4:0]                 result_reg_o,
    input logic [`ISSUE_TAG_BITS-1:0] result_tag_o,
    input logic                       result_taken_o,
    input data_word_t                 result_target_o,
    input logic                       writeback,
    input logic                       unit_empty
);

    // A stalled result keeps all of its fields.
    result_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_data_o)
        && $stable(result_reg_o) && $stable(result_tag_o) && $stable(result_taken_o)
        && $stable(result_target_o))
        else $error("result fields changed while stalled");

    // Fence waits for the unit to drain.
    fence_drain_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i && instr_ready_o && fence_i |-> !result_valid_o && unit_empty)
        else $error("fence transferred with results outstanding");

    // Writeback and issue never hit the same destination in one cycle.
    wb_issue_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        writeback && instr_valid_i && instr_ready_o && !fence_i
        |-> (dest_reg_i != result_reg_o) || (is_branch_i && !uop_i.branch.link))
        else $error("issue and writeback targeted the same register");

    flush_empty_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !result_valid_o && unit_empty)
        else $error("queue not empty after flush");

endmodule : issue_stage_chk

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40                    // Full clock period.
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) clk_o = ~clk_o;            // Half period per phase.
    end

endmodule : tb_clock

// File: logic/issue_stage.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module issue_stage
    import apogeo_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,

    input  logic                       instr_valid_i,
    output logic                       instr_ready_o,
    input  exu_uop_t                   uop_i,
    input  logic                       is_branch_i,
    input  logic                       jump_i,
    input  logic                       compressed_i,
    input  logic                       fence_i,
    input  logic [1:0][4:0]            src_reg_i,
    input  logic [4:0]                 dest_reg_i,
    input  data_word_t [1:0]           imm_i,
    input  logic [1:0]                 imm_valid_i,
    input  logic                       target_base_i,
    input  data_word_t                 instr_address_i,

    output logic                       result_valid_o,
    input  logic                       result_ready_i,
    output data_word_t                 result_data_o,
    output logic [4:0]                 result_reg_o,
    output logic [`ISSUE_TAG_BITS-1:0] result_tag_o,
    output logic                       result_taken_o,
    output data_word_t                 result_target_o
);

    logic                       exu_valid;
    logic                       exu_ready;
    data_word_t [1:0]           operand;
    exu_uop_t                   uop;
    logic                       is_branch;
    logic                       jump;
    logic [4:0]                 dest_reg;
    logic [`ISSUE_TAG_BITS-1:0] tag;
    data_word_t                 target;
    logic                       writeback;              // Result transfer to a real register.
    logic                       unit_empty;

    scheduler i_scheduler (
        .clk_i            ( clk_i           ),
        .rst_n_i          ( rst_n_i         ),
        .flush_i          ( flush_i         ),
        .instr_valid_i    ( instr_valid_i   ),
        .instr_ready_o    ( instr_ready_o   ),
        .uop_i            ( uop_i           ),
        .is_branch_i      ( is_branch_i     ),
        .jump_i           ( jump_i          ),
        .compressed_i     ( compressed_i    ),
        .fence_i          ( fence_i         ),
        .src_reg_i        ( src_reg_i       ),
        .dest_reg_i       ( dest_reg_i      ),
        .imm_i            ( imm_i           ),
        .imm_valid_i      ( imm_valid_i     ),
        .target_base_i    ( target_base_i   ),
        .instr_address_i  ( instr_address_i ),
        .exu_valid_o      ( exu_valid       ),
        .exu_ready_i      ( exu_ready       ),
        .operand_o        ( operand         ),
        .uop_o            ( uop             ),
        .is_branch_o      ( is_branch       ),
        .jump_o           ( jump            ),
        .dest_reg_o       ( dest_reg        ),
        .tag_o            ( tag             ),
        .target_o         ( target          ),
        .writeback_i      ( writeback       ),
        .writeback_reg_i  ( result_reg_o    ),  // Writeback rides on the result port.
        .writeback_data_i ( result_data_o   ),
        .unit_empty_i     ( unit_empty      )
    );

    integer_unit #(
        .QUEUE_DEPTH ( `ISSUE_QUEUE_DEPTH )
    ) i_integer_unit (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .flush_i         ( flush_i         ),
        .exu_valid_i     ( exu_valid       ),
        .exu_ready_o     ( exu_ready       ),
        .operand_i       ( operand         ),
        .uop_i           ( uop             ),
        .is_branch_i     ( is_branch       ),
        .jump_i          ( jump            ),
        .dest_reg_i      ( dest_reg        ),
        .tag_i           ( tag             ),
        .target_i        ( target          ),
        .result_valid_o  ( result_valid_o  ),
        .result_ready_i  ( result_ready_i  ),
        .result_data_o   ( result_data_o   ),
        .result_reg_o    ( result_reg_o    ),
        .result_tag_o    ( result_tag_o    ),
        .result_taken_o  ( result_taken_o  ),
        .result_target_o ( result_target_o ),
        .writeback_o     ( writeback       ),
        .empty_o         ( unit_empty      )
    );

endmodule : issue_stage

// File: logic/integer_unit.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module integer_unit
    import apogeo_pkg::*;
#(
    parameter int QUEUE_DEPTH = `ISSUE_QUEUE_DEPTH
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,

    input  logic                       exu_valid_i,
    output logic                       exu_ready_o,
    input  data_word_t [1:0]           operand_i,
    input  exu_uop_t                   uop_i,
    input  logic                       is_branch_i,
    input  logic                       jump_i,
    input  logic [4:0]                 dest_reg_i,
    input  logic [`ISSUE_TAG_BITS-1:0] tag_i,
    input  data_word_t                 target_i,

    output logic                       result_valid_o,
    input  logic                       result_ready_i,
    output data_word_t                 result_data_o,
    output logic [4:0]                 result_reg_o,
    output logic [`ISSUE_TAG_BITS-1:0] result_tag_o,
    output logic                       result_taken_o,
    output data_word_t                 result_target_o,
    output logic                       writeback_o,
    output logic                       empty_o
);

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    data_word_t                 alu_data;
    logic                       taken;
    logic [4:0]                 res_reg;
    data_word_t                 q_data   [QUEUE_DEPTH];
    logic [4:0]                 q_reg    [QUEUE_DEPTH];
    logic [`ISSUE_TAG_BITS-1:0] q_tag    [QUEUE_DEPTH];
    logic                       q_taken  [QUEUE_DEPTH];
    data_word_t                 q_target [QUEUE_DEPTH];
    logic [PTR_BITS-1:0]        wr_ptr;
    logic [PTR_BITS-1:0]        rd_ptr;
    logic [CNT_BITS-1:0]        count;
    logic                       push;
    logic                       pop;

    always_comb begin
        taken    = 1'b0;
        alu_data = '0;
        if (is_branch_i) begin
            case (uop_i.branch.cond)
                BR_EQ:     taken = (operand_i[0] == operand_i[1]);
                BR_NE:     taken = (operand_i[0] != operand_i[1]);
                BR_LT:     taken = ($signed(operand_i[0]) <  $signed(operand_i[1]));
                BR_GE:     taken = ($signed(operand_i[0]) >= $signed(operand_i[1]));
                BR_ALWAYS: taken = 1'b1;
                default:   taken = 1'b0;
            endcase
            if (jump_i) begin
                alu_data = operand_i[0] + operand_i[1]; // Return address.
            end
        end else begin
            case (uop_i.alu.op)
                ALU_ADD: alu_data = operand_i[0] + operand_i[1];
                ALU_SUB: alu_data = operand_i[0] - operand_i[1];
                ALU_AND: alu_data = operand_i[0] & operand_i[1];
                ALU_OR:  alu_data = operand_i[0] | operand_i[1];
                ALU_XOR: alu_data = operand_i[0] ^ operand_i[1];
                ALU_SLT: alu_data = data_word_t'($signed(operand_i[0]) < $signed(operand_i[1]));
                ALU_SLL: alu_data = operand_i[0] << operand_i[1][4:0];
                ALU_SRL: alu_data = operand_i[0] >> operand_i[1][4:0];
                default: alu_data = '0;
            endcase
        end
    end

    // A branch without link writes nothing.
    assign res_reg = (is_branch_i && !uop_i.branch.link) ? 5'd0 : dest_reg_i;

    assign exu_ready_o    = (count != CNT_BITS'(QUEUE_DEPTH));  // Free entry left.
    assign result_valid_o = (count != '0);
    assign empty_o        = (count == '0);
    assign push           = exu_valid_i & exu_ready_o;
    assign pop            = result_valid_o & result_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            q_data[wr_ptr]   <= alu_data;
            q_reg[wr_ptr]    <= res_reg;
            q_tag[wr_ptr]    <= tag_i;
            q_taken[wr_ptr]  <= taken;
            q_target[wr_ptr] <= target_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;                           // Queued results dropped.
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign result_data_o   = q_data[rd_ptr];
    assign result_reg_o    = q_reg[rd_ptr];
    assign result_tag_o    = q_tag[rd_ptr];
    assign result_taken_o  = q_taken[rd_ptr];
    assign result_target_o = q_target[rd_ptr];
    assign writeback_o     = pop & (q_reg[rd_ptr] != 5'd0);  // Register file write.

endmodule : integer_unit

// File: logic/scheduler.sv
`timescale 1ns/1ps

`include "issue_config.svh"

module scheduler
    import apogeo_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       flush_i,

    input  logic                       instr_valid_i,
    output logic                       instr_ready_o,
    input  exu_uop_t                   uop_i,
    input  logic                       is_branch_i,
    input  logic                       jump_i,
    input  logic                       compressed_i,
    input  logic                       fence_i,
    input  logic [1:0][4:0]            src_reg_i,
    input  logic [4:0]                 dest_reg_i,
    input  data_word_t [1:0]           imm_i,
    input  logic [1:0]                 imm_valid_i,
    input  logic                       target_base_i,
    input  data_word_t                 instr_address_i,

    output logic                       exu_valid_o,
    input  logic                       exu_ready_i,
    output data_word_t [1:0]           operand_o,
    output exu_uop_t                   uop_o,
    output logic                       is_branch_o,
    output logic                       jump_o,
    output logic [4:0]                 dest_reg_o,
    output logic [`ISSUE_TAG_BITS-1:0] tag_o,
    output data_word_t                 target_o,

    input  logic                       writeback_i,
    input  logic [4:0]                 writeback_reg_i,
    input  data_word_t                 writeback_data_i,
    input  logic                       unit_empty_i
);

    data_word_t [1:0]            reg_data;
    logic [1:0]                  src_used;
    logic [4:0]                  sb_dest;
    logic                        sb_clear;
    logic                        sb_drained;
    logic                        issue;
    logic [`ISSUE_TAG_BITS-1:0]  tag_q;

    register_file i_register_file (
        .clk_i        ( clk_i            ),
        .write_i      ( writeback_i      ),
        .write_reg_i  ( writeback_reg_i  ),
        .write_data_i ( writeback_data_i ),
        .read_reg_i   ( src_reg_i        ),
        .read_data_o  ( reg_data         )
    );

    // A jump reads no register operand, only a register target base.
    assign src_used[0] = (~jump_i & ~imm_valid_i[0]) | target_base_i;
    assign src_used[1] = ~jump_i & ~imm_valid_i[1];

    // A branch without link writes no register, so nothing becomes pending.
    assign sb_dest = (is_branch_i && !uop_i.branch.link) ? 5'd0 : dest_reg_i;

    scoreboard i_scoreboard (
        .clk_i         ( clk_i           ),
        .rst_n_i       ( rst_n_i         ),
        .flush_i       ( flush_i         ),
        .issue_i       ( issue           ),
        .src_reg_i     ( src_reg_i       ),
        .src_used_i    ( src_used        ),
        .dest_reg_i    ( sb_dest         ),
        .release_i     ( writeback_i     ),
        .release_reg_i ( writeback_reg_i ),
        .unit_empty_i  ( unit_empty_i    ),
        .clear_o       ( sb_clear        ),
        .drained_o     ( sb_drained      )
    );

    assign instr_ready_o = sb_clear & exu_ready_i & (~fence_i | sb_drained);
    assign exu_valid_o   = instr_valid_i & ~fence_i & sb_clear;  // Fence carries no work.
    assign issue         = exu_valid_o & exu_ready_i;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (imm_valid_i[i]) begin
                operand_o[i] = imm_i[i];
            end else begin
                operand_o[i] = reg_data[i];
            end
        end
        if (jump_i) begin
            operand_o[0] = instr_address_i;         // Link is PC plus length.
            operand_o[1] = compressed_i ? data_word_t'(2) : data_word_t'(4);
        end
    end

    // Base is the PC or rs1, offset is the second immediate.
    assign target_o = (target_base_i ? reg_data[0] : instr_address_i) + imm_i[1];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tag_q <= '0;
        end else if (flush_i) begin
            tag_q <= '0;
        end else if (issue) begin
            tag_q <= tag_q + 1'b1;                  // Wraps at the tag width.
        end
    end

    assign tag_o       = tag_q;
    assign uop_o       = uop_i;
    assign is_branch_o = is_branch_i;
    assign jump_o      = jump_i;
    assign dest_reg_o  = dest_reg_i;

endmodule : scheduler

// File: logic/scoreboard.sv
`timescale 1ns/1ps

module scoreboard (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic            issue_i,
    input  logic [1:0][4:0] src_reg_i,
    input  logic [1:0]      src_used_i,
    input  logic [4:0]      dest_reg_i,
    input  logic            release_i,
    input  logic [4:0]      release_reg_i,
    input  logic            unit_empty_i,
    output logic            clear_o,
    output logic            drained_o
);

    logic [31:0] pending;                           // Bit 0 stays low.
    logic [31:0] pending_next;
    logic [1:0]  src_hazard;

    always_comb begin
        pending_next = pending;
        if (release_i) begin
            pending_next[release_reg_i] = 1'b0;     // Writeback done.
        end
        if (issue_i && (dest_reg_i != 5'd0)) begin
            pending_next[dest_reg_i] = 1'b1;        // Result now in flight.
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending <= '0;
        end else if (flush_i) begin
            pending <= '0;                          // Issued work is discarded.
        end else begin
            pending <= pending_next;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src_hazard[i] = src_used_i[i] & pending[src_reg_i[i]];
        end
    end

    // Also blocks a write-after-write on the same register.
    assign clear_o   = ~|src_hazard & ~pending[dest_reg_i];
    assign drained_o = ~|pending & unit_empty_i;    // Fence may proceed.

endmodule : scoreboard

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file
    import apogeo_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 write_i,
    input  logic [4:0]           write_reg_i,
    input  data_word_t           write_data_i,
    input  logic [1:0][4:0]      read_reg_i,
    output data_word_t [1:0]     read_data_o
);

    data_word_t regs [32];                          // Entry 0 is never written.

    always_ff @(posedge clk_i) begin
        if (write_i && (write_reg_i != 5'd0)) begin
            regs[write_reg_i] <= write_data_i;      // x0 writes dropped.
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            if (read_reg_i[i] == 5'd0) begin
                read_data_o[i] = '0;                // x0 reads zero.
            end else begin
                read_data_o[i] = regs[read_reg_i[i]];
            end
        end
    end

endmodule : register_file

// File: logic/apogeo_pkg.sv
`include "issue_config.svh"

package apogeo_pkg;

    typedef logic [`ISSUE_XLEN-1:0] data_word_t;   // One register word.

    typedef enum logic [3:0] {
        ALU_ADD,                                    // Sum.
        ALU_SUB,                                    // Difference.
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                                    // Signed set less than.
        ALU_SLL,                                    // Shift left logical.
        ALU_SRL                                     // Shift right logical.
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_EQ,
        BR_NE,
        BR_LT,                                      // Signed less than.
        BR_GE,                                      // Signed greater or equal.
        BR_ALWAYS                                   // Jumps.
    } branch_cond_t;

    typedef struct packed {
        logic [3:0] pad;                            // Unused upper nibble.
        alu_op_t    op;                             // Arithmetic operation.
    } alu_uop_t;

    typedef struct packed {
        logic [3:0]   pad;                          // Unused upper nibble.
        logic         link;                         // Result goes to dest register.
        branch_cond_t cond;                         // Condition on the operands.
    } branch_uop_t;

    // The same micro-op byte, read through is_branch.
    typedef union packed {
        alu_uop_t    alu;
        branch_uop_t branch;
    } exu_uop_t;

endpackage : apogeo_pkg

// File: logic/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// Register and datapath width.
`define ISSUE_XLEN 32

// Reorder tag width.
`define ISSUE_TAG_BITS 6

// Entries in the integer unit result queue.
`define ISSUE_QUEUE_DEPTH 2

`endif
